// ==== beat/beat_detector.sv ====
////////////////////
// beat finder on strobed audio power samples
// a beat is a quiet to loud step between two strobed samples
// beating holds for BEAT_HOLD_SAMPLES strobes after the last beat
////////////////////
`timescale 1ns/1ps

`include "dance_consts.svh"

module beat_detector (
  input  logic              frame_clk,
  input  logic              reset,
  input  dance_pkg::power_t sample_power,
  input  logic              sample_strobe,
  output logic              beat_hit,
  output logic              beating
);

  localparam dance_pkg::power_t    beat_threshold = dance_pkg::power_t'(`BEAT_THRESHOLD);
  localparam dance_pkg::hold_cnt_t hold_load = dance_pkg::hold_cnt_t'(`BEAT_HOLD_SAMPLES);

  // strictly above threshold
  logic loud;

  // the previous strobed sample was loud
  logic last_loud;

  // rising edge of loudness on this strobe
  logic new_beat;

  // samples left before beating drops
  dance_pkg::hold_cnt_t hold_cnt;

  assign loud     = (sample_power > beat_threshold);
  assign new_beat = sample_strobe && loud && !last_loud;

  always_ff @(posedge frame_clk) begin
    if (reset) begin
      last_loud <= 1'b0;
      beat_hit  <= 1'b0;
      hold_cnt  <= '0;
    end else begin
      beat_hit <= new_beat;
      if (sample_strobe) begin
        last_loud <= loud;
        if (new_beat) begin
          hold_cnt <= hold_load;
        end else if (hold_cnt != '0) begin
          // one more sample without a fresh beat
          hold_cnt <= hold_cnt - dance_pkg::hold_cnt_t'(1);
        end
      end
    end
  end

  // counter is a register so this level is glitch free
  // rises with beat_hit, falls after the strobe that empties the count
  assign beating = (hold_cnt != '0);

endmodule

// ==== bench/dance_floor_chk.sv ====
////////////////////
// bound checks on the dance top
// pulse widths, move timing and step size
////////////////////
`timescale 1ns/1ps

`include "dance_consts.svh"

module dance_floor_chk (
  input logic                  frame_clk,
  input logic                  reset,
  input logic                  frame_start,
  input logic                  beat_hit,
  input scan_pkg::screen_pos_t dancer_pos [`NUM_DANCERS]
);

  // failed assertions, read by the testbench at the end
  int fail_count = 0;

  // one diagonal pixel either way, 10 and 9 bit wrap included
  function automatic bit one_step(input scan_pkg::screen_pos_t now,
                                  input scan_pkg::screen_pos_t was);
    scan_pkg::pix_x_t dx;
    scan_pkg::pix_y_t dy;
    dx = now.x - was.x;
    dy = now.y - was.y;
    return (dx == 1 && dy == 1) || (dx == '1 && dy == '1);
  endfunction

  frame_pulse_a: assert property (@(posedge frame_clk) disable iff (reset)
    frame_start |=> !frame_start)
    else begin
      $error("frame_start stayed high for two cycles");
      fail_count++;
    end

  beat_pulse_a: assert property (@(posedge frame_clk) disable iff (reset)
    beat_hit |=> !beat_hit)
    else begin
      $error("beat_hit stayed high for two cycles");
      fail_count++;
    end

  for (genvar i = 0; i < `NUM_DANCERS; i++) begin : g_dancer
    // a move is only allowed right after a frame tick
    move_timing_a: assert property (@(posedge frame_clk) disable iff (reset)
      !$stable(dancer_pos[i]) |-> $past(frame_start))
      else begin
        $error("dancer %0d moved without a frame tick", i);
        fail_count++;
      end

    step_size_a: assert property (@(posedge frame_clk) disable iff (reset)
      !$stable(dancer_pos[i]) |-> one_step(dancer_pos[i], $past(dancer_pos[i])))
      else begin
        $error("dancer %0d moved by more than one diagonal pixel", i);
        fail_count++;
      end
  end

endmodule

bind dance_floor_top dance_floor_chk chk (
  .frame_clk  (frame_clk),
  .reset      (reset),
  .frame_start(frame_start),
  .beat_hit   (beat_hit),
  .dancer_pos (dancer_pos)
);

// ==== bench/dance_floor_monitor.sv ====
////////////////////
// compares DUT outputs with the model on every falling edge
// idle until check_en
// an X from the DUT counts as a mismatch
////////////////////
`timescale 1ns/1ps

`include "dance_consts.svh"

module dance_floor_monitor (
  input  logic                     frame_clk,
  input  logic                     check_en,
  input  int                       test_id,
  input  logic                     test_done,
  input  logic                     run_done,
  input  scan_pkg::screen_pos_t    dut_pos [`NUM_DANCERS],
  input  dance_pkg::dance_status_t dut_status,
  input  scan_pkg::screen_pos_t    exp_pos [`NUM_DANCERS],
  input  dance_pkg::dance_status_t exp_status,
  output int                       error_count
);

  int errors = 0;
  int checks = 0;
  int test_checks = 0;
  int test_errors = 0;
  int tests_run = 0;

  assign error_count = errors;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset";
      2: return "beat detection";
      3: return "stepping";
      4: return "sway direction";
      5: return "mid-run reset";
      default: return "unknown";
    endcase
  endfunction

  // outputs settle well before the falling edge
  always @(negedge frame_clk) begin
    if (check_en) begin
      for (int i = 0; i < `NUM_DANCERS; i++) begin
        checks++;
        test_checks++;
        if (dut_pos[i] !== exp_pos[i]) begin
          $display("[FAIL] %s: dancer %0d position expected (%0d,%0d) actual (%0d,%0d)",
                   test_name(test_id), i, exp_pos[i].x, exp_pos[i].y,
                   dut_pos[i].x, dut_pos[i].y);
          errors++;
          test_errors++;
        end
      end
      checks++;
      test_checks++;
      // bits are frame_start, beat_hit, beating, direction
      if (dut_status !== exp_status) begin
        $display("[FAIL] %s: status expected %b actual %b",
                 test_name(test_id), exp_status, dut_status);
        errors++;
        test_errors++;
      end
    end
    if (test_done) begin
      $display("test %s finished: %0d checks, %0d errors",
               test_name(test_id), test_checks, test_errors);
      tests_run++;
      test_checks = 0;
      test_errors = 0;
    end
    if (run_done) begin
      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    end
  end

endmodule

// ==== bench/dance_floor_tb.sv ====
////////////////////
// testbench for the dance motion top with step_frames at 4
// audio strobes every third cycle from a free running divider
// loud filler power sits between strobes and must never count
// the model follows the block timing rules cycle by cycle
////////////////////
`timescale 1ns/1ps

`include "dance_consts.svh"

module dance_floor_tb;

  localparam int step_frames = 4;
  localparam int total_frames = 10 + 43 + 75 + 300 + 20;
  localparam int frame_cycles = 8;
  localparam int watchdog_ns = (total_frames * frame_cycles + 400) * 8;

  logic                     frame_clk = 1'b0;
  logic                     reset;
  scan_pkg::screen_pos_t    scan_pos;
  dance_pkg::power_t        sample_power = '0;
  logic                     sample_strobe = 1'b0;
  dance_pkg::dancer_en_t    dancer_en;
  scan_pkg::screen_pos_t    home [`NUM_DANCERS];
  scan_pkg::screen_pos_t    dancer_pos [`NUM_DANCERS];
  dance_pkg::dance_status_t status;

  // pulsed gives one loud sample and then a gap of quiet samples
  integer seed = 32'h2146_93d8;
  int     strobe_div = 0;
  int     gap_cnt = 0;
  int     gap_a = 8;
  int     gap_b = 8;
  logic   use_b = 1'b0;
  logic   pulsed = 1'b0;

  // model state
  logic                  m_armed;
  logic                  m_frame_start;
  logic                  m_last_loud;
  logic                  m_beat_hit;
  int                    m_hold;
  dance_pkg::step_dir_t  m_dir;
  int                    m_cnt [`NUM_DANCERS];
  scan_pkg::screen_pos_t m_pos [`NUM_DANCERS];
  dance_pkg::dance_status_t exp_status;

  logic check_en = 1'b0;
  logic test_done = 1'b0;
  logic run_done = 1'b0;
  int   test_id = 1;
  int   mon_errors;

  always #4 frame_clk = ~frame_clk;

  dance_floor_top #(
    .step_frames(step_frames)
  ) DUT (
    .frame_clk    (frame_clk),
    .reset        (reset),
    .scan_pos     (scan_pos),
    .sample_power (sample_power),
    .sample_strobe(sample_strobe),
    .dancer_en    (dancer_en),
    .home         (home),
    .dancer_pos   (dancer_pos),
    .status       (status)
  );

  dance_floor_monitor mon (
    .frame_clk  (frame_clk),
    .check_en   (check_en),
    .test_id    (test_id),
    .test_done  (test_done),
    .run_done   (run_done),
    .dut_pos    (dancer_pos),
    .dut_status (status),
    .exp_pos    (m_pos),
    .exp_status (exp_status),
    .error_count(mon_errors)
  );

  function automatic dance_pkg::power_t quiet_power();
    return dance_pkg::power_t'($unsigned($random(seed)) % (`BEAT_THRESHOLD + 1));
  endfunction

  function automatic dance_pkg::power_t loud_power();
    return dance_pkg::power_t'(`BEAT_THRESHOLD + 1 +
                               $unsigned($random(seed)) % (2047 - `BEAT_THRESHOLD));
  endfunction

  // loud is strictly above the threshold
  function automatic bit is_loud(input int p);
    return p > `BEAT_THRESHOLD;
  endfunction

  // hold count one cycle later
  function automatic int next_hold(input int hold, input bit strobe, input bit beat);
    if (beat) return `BEAT_HOLD_SAMPLES;
    if (strobe && hold > 0) return hold - 1;
    return hold;
  endfunction

  // lead dancer tolerance rule that toggles inside the window
  function automatic dance_pkg::step_dir_t sway_rule(input dance_pkg::step_dir_t dir,
                                                     input int lead_x, input int home_x);
    if (lead_x < home_x - `SWAY_TOL) return dance_pkg::step_forward;
    if (lead_x > home_x + `SWAY_TOL) return dance_pkg::step_backward;
    return (dir == dance_pkg::step_forward) ? dance_pkg::step_backward : dance_pkg::step_forward;
  endfunction

  function automatic scan_pkg::screen_pos_t diagonal_step(input scan_pkg::screen_pos_t p,
                                                          input dance_pkg::step_dir_t dir);
    scan_pkg::screen_pos_t n;
    int d;
    d = (dir == dance_pkg::step_forward) ? 1 : -1;
    n.x = scan_pkg::pix_x_t'(int'(p.x) + d);
    n.y = scan_pkg::pix_y_t'(int'(p.y) + d);
    return n;
  endfunction

  // reference model on the same pre-edge inputs as the DUT
  always @(posedge frame_clk) begin
    bit beat_now;
    beat_now = sample_strobe && is_loud(sample_power) && !m_last_loud;
    if (reset) begin
      m_armed <= 1'b0;
      m_frame_start <= 1'b0;
      m_last_loud <= 1'b0;
      m_beat_hit <= 1'b0;
      m_hold <= 0;
      m_dir <= dance_pkg::step_forward;
      for (int i = 0; i < `NUM_DANCERS; i++) begin
        m_cnt[i] <= 0;
        m_pos[i] <= home[i];
      end
    end else begin
      // a frame at the origin disarms whether or not it fired
      m_frame_start <= m_armed && (scan_pos == '0);
      m_armed <= (scan_pos != '0);
      m_beat_hit <= beat_now;
      if (sample_strobe) m_last_loud <= is_loud(sample_power);
      m_hold <= next_hold(m_hold, sample_strobe, beat_now);
      if (m_beat_hit) m_dir <= sway_rule(m_dir, m_pos[0].x, home[0].x);
      for (int i = 0; i < `NUM_DANCERS; i++) begin
        if (m_frame_start && m_cnt[i] == step_frames && dancer_en[i] && m_hold != 0) begin
          m_pos[i] <= diagonal_step(m_pos[i], m_dir);
          m_cnt[i] <= 0;
        end else if (m_frame_start && m_cnt[i] < step_frames) begin
          m_cnt[i] <= m_cnt[i] + 1;
        end
      end
    end
  end

  assign exp_status = '{frame_start: m_frame_start, beat_hit: m_beat_hit,
                        beating: (m_hold != 0), direction: m_dir};

  // audio source with one strobe every third cycle
  always @(posedge frame_clk) begin
    sample_strobe <= (strobe_div == 2);
    strobe_div <= (strobe_div == 2) ? 0 : strobe_div + 1;
    if (strobe_div == 2) begin
      if (pulsed && gap_cnt == 0) begin
        sample_power <= loud_power();
        gap_cnt <= use_b ? gap_b : gap_a;
        use_b <= !use_b;
      end else begin
        sample_power <= quiet_power();
        if (gap_cnt != 0) gap_cnt <= gap_cnt - 1;
      end
    end else begin
      // unstrobed filler stays loud
      sample_power <= loud_power();
    end
  end

  // len cycles per frame with the last two at the origin
  task automatic run_frames(input int n, input int len);
    for (int f = 0; f < n; f++) begin
      for (int c = 0; c < len; c++) begin
        @(posedge frame_clk);
        if (c < len - 2) begin
          scan_pos <= '{x: scan_pkg::pix_x_t'(c + 1), y: scan_pkg::pix_y_t'(f % 480)};
        end else begin
          scan_pos <= '0;
        end
      end
    end
  endtask

  task automatic finish_test(input int next_id);
    @(posedge frame_clk);
    test_done <= 1'b1;
    @(posedge frame_clk);
    test_done <= 1'b0;
    test_id <= next_id;
  endtask

  task automatic apply_reset();
    @(posedge frame_clk);
    reset <= 1'b1;
    repeat (3) @(posedge frame_clk);
    reset <= 1'b0;
  endtask

  initial begin
    #(watchdog_ns);
    $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    reset = 1'b1;
    scan_pos = '0;
    dancer_en = '0;
    for (int i = 0; i < `NUM_DANCERS; i++) begin
      home[i] = '{x: scan_pkg::pix_x_t'(120 + 100 * i), y: scan_pkg::pix_y_t'(200 + 10 * i)};
    end
    @(posedge frame_clk);
    check_en <= 1'b1;
    repeat (2) @(posedge frame_clk);
    reset <= 1'b0;
    // quiet music and frames only
    run_frames(10, 8);
    finish_test(2);
    run_frames(3, 8);
    gap_a <= 0;
    gap_b <= 0;
    pulsed <= 1'b1;
    run_frames(5, 8);
    // loud and quiet alternate on every strobe
    gap_a <= 1;
    gap_b <= 1;
    run_frames(5, 8);
    pulsed <= 1'b0;
    run_frames(30, 8);
    finish_test(3);
    // dancer 2 stays home
    dancer_en <= 4'b1011;
    gap_a <= 8;
    gap_b <= 8;
    pulsed <= 1'b1;
    run_frames(40, 8);
    pulsed <= 1'b0;
    run_frames(35, 8);
    finish_test(4);
    // uneven beat spacing lets the lead drift past the tolerance
    dancer_en <= 4'b1111;
    gap_a <= 60;
    gap_b <= 20;
    pulsed <= 1'b1;
    run_frames(300, 4);
    finish_test(5);
    gap_a <= 8;
    gap_b <= 8;
    run_frames(10, 8);
    apply_reset();
    run_frames(10, 8);
    finish_test(5);
    @(posedge frame_clk);
    run_done <= 1'b1;
    @(posedge frame_clk);
    run_done <= 1'b0;
    @(posedge frame_clk);
    if (mon_errors == 0 && DUT.chk.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== common/dance_consts.svh ====
////////////////////
// build constants for the dance motion block
// values are plain integers and each user casts to its own width
// BEAT_THRESHOLD must fit power_t, BEAT_HOLD_SAMPLES must fit hold_cnt_t
////////////////////
`ifndef DANCE_CONSTS_SVH
`define DANCE_CONSTS_SVH

// number of dancer sprites, dancer 0 leads the sway
`define NUM_DANCERS 4

// audio power above this counts as a loud sample
`define BEAT_THRESHOLD 600

// strobed samples that beating stays high after a beat
`define BEAT_HOLD_SAMPLES 64

// frames between steps, 360 is six seconds at 60 Hz
`define STEP_FRAMES 360

// pixels the lead may drift in x before direction is forced
`define SWAY_TOL 7

`endif

// ==== common/dance_pkg.sv ====
////////////////////
// audio and motion types for the dance block
// dancer_en_t width follows NUM_DANCERS
////////////////////
`include "dance_consts.svh"

package dance_pkg;

  // audio power sample from the front end
  typedef logic [10:0] power_t;

  // one enable bit per dancer, bit 0 is the lead
  typedef logic [`NUM_DANCERS-1:0] dancer_en_t;

  // beat hold down-counter, holds up to 127 samples
  typedef logic [6:0] hold_cnt_t;

  // diagonal sway direction
  // forward moves x and y up, backward moves both down
  typedef enum logic {
    step_backward = 1'b0,
    step_forward  = 1'b1
  } step_dir_t;

  // flags for the board LEDs
  typedef struct packed {
    logic      frame_start;
    logic      beat_hit;
    logic      beating;
    step_dir_t direction;
  } dance_status_t;

endpackage

// ==== common/scan_pkg.sv ====
////////////////////
// screen coordinate types for a 640x480 display
// x is 10 bits and y is 9 bits, no range checking
////////////////////
package scan_pkg;

  // horizontal pixel, 0..639 on screen
  typedef logic [9:0] pix_x_t;

  // vertical pixel, 0..479 on screen
  typedef logic [8:0] pix_y_t;

  // x in the upper bits, y in the lower bits
  // used both for the scan position and a sprite's top-left corner
  typedef struct packed {
    pix_x_t x;
    pix_y_t y;
  } screen_pos_t;

endpackage

// ==== filelist.f ====
+incdir+common
common/scan_pkg.sv
common/dance_pkg.sv
verilog/frame_tick.sv
beat/beat_detector.sv
motion/dancer_mover.sv
motion/motion_manager.sv
verilog/dance_floor_top.sv
bench/dance_floor_chk.sv
bench/dance_floor_monitor.sv
bench/dance_floor_tb.sv

// ==== motion/dancer_mover.sv ====
////////////////////
// one dancer's diagonal stepping
// steps once per step_frames + 1 frame ticks while beating
// position wraps silently at the coordinate limits
////////////////////
`timescale 1ns/1ps

`include "dance_consts.svh"

module dancer_mover #(
  parameter int step_frames = `STEP_FRAMES
) (
  input  logic                  frame_clk,
  input  logic                  reset,
  input  logic                  frame_start,
  input  logic                  beating,
  input  logic                  enable,
  input  dance_pkg::step_dir_t  direction,
  input  scan_pkg::screen_pos_t home,
  output scan_pkg::screen_pos_t pos
);

  // counter wide enough to hold step_frames itself
  localparam int cnt_w = (step_frames < 1) ? 1 : $clog2(step_frames + 1);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(step_frames);

  localparam scan_pkg::pix_x_t x_one = scan_pkg::pix_x_t'(1);
  localparam scan_pkg::pix_y_t y_one = scan_pkg::pix_y_t'(1);

  // frames since the last step, saturating
  logic [cnt_w-1:0] frame_cnt;

  // counter is full at this frame tick and the music allows a step
  logic step_now;

  assign step_now = frame_start && (frame_cnt == cnt_max) && enable && beating;

  always_ff @(posedge frame_clk) begin
    if (reset) begin
      frame_cnt <= '0;
      pos       <= home;
    end else if (step_now) begin
      frame_cnt <= '0;
      if (direction == dance_pkg::step_forward) begin
        pos.x <= pos.x + x_one;
        pos.y <= pos.y + y_one;
      end else begin
        pos.x <= pos.x - x_one;
        pos.y <= pos.y - y_one;
      end
    end else if (frame_start && (frame_cnt != cnt_max)) begin
      // a full counter just waits for beating or enable
      frame_cnt <= frame_cnt + cnt_w'(1);
    end
  end

endmodule

// ==== motion/motion_manager.sv ====
////////////////////
// sway direction and the per-dancer movers
// direction follows dancer 0 against its home x only
// home must stay stable while out of reset
////////////////////
`timescale 1ns/1ps

`include "dance_consts.svh"

module motion_manager #(
  parameter int step_frames = `STEP_FRAMES
) (
  input  logic                  frame_clk,
  input  logic                  reset,
  input  logic                  frame_start,
  input  logic                  beat_hit,
  input  logic                  beating,
  input  dance_pkg::dancer_en_t dancer_en,
  input  scan_pkg::screen_pos_t home [`NUM_DANCERS],
  output scan_pkg::screen_pos_t dancer_pos [`NUM_DANCERS],
  output dance_pkg::step_dir_t  direction
);

  // one extra bit so home +/- tolerance cannot wrap
  localparam logic [10:0] sway_tol = 11'(`SWAY_TOL);

  logic [10:0] lead_x;
  logic [10:0] lead_home_x;

  // lead has drifted too far left or right
  logic too_far_back;
  logic too_far_fwd;

  assign lead_x      = {1'b0, dancer_pos[0].x};
  assign lead_home_x = {1'b0, home[0].x};

  // x < home - tol rewritten as x + tol < home
  assign too_far_back = (lead_x + sway_tol) < lead_home_x;
  assign too_far_fwd  = lead_x > (lead_home_x + sway_tol);

  always_ff @(posedge frame_clk) begin
    if (reset) begin
      direction <= dance_pkg::step_forward;
    end else if (beat_hit) begin
      if (too_far_back) begin
        direction <= dance_pkg::step_forward;
      end else if (too_far_fwd) begin
        direction <= dance_pkg::step_backward;
      end else if (direction == dance_pkg::step_forward) begin
        direction <= dance_pkg::step_backward;
      end else begin
        direction <= dance_pkg::step_forward;
      end
    end
  end

  // all movers share the direction and the frame and beat timing
  for (genvar i = 0; i < `NUM_DANCERS; i++) begin : g_mover
    dancer_mover #(
      .step_frames(step_frames)
    ) u_mover (
      .frame_clk  (frame_clk),
      .reset      (reset),
      .frame_start(frame_start),
      .beating    (beating),
      .enable     (dancer_en[i]),
      .direction  (direction),
      .home       (home[i]),
      .pos        (dancer_pos[i])
    );
  end

endmodule

// ==== verilog/dance_floor_top.sv ====
////////////////////
// dance motion top, everything on frame_clk
// audio strobe must already be synchronous to frame_clk
// status bits all come straight from registers
////////////////////
`timescale 1ns/1ps

`include "dance_consts.svh"

module dance_floor_top #(
  parameter int step_frames = `STEP_FRAMES
) (
  input  logic                     frame_clk,
  input  logic                     reset,
  input  scan_pkg::screen_pos_t    scan_pos,
  input  dance_pkg::power_t        sample_power,
  input  logic                     sample_strobe,
  input  dance_pkg::dancer_en_t    dancer_en,
  input  scan_pkg::screen_pos_t    home [`NUM_DANCERS],
  output scan_pkg::screen_pos_t    dancer_pos [`NUM_DANCERS],
  output dance_pkg::dance_status_t status
);

  logic                 frame_start;
  logic                 beat_hit;
  logic                 beating;
  dance_pkg::step_dir_t direction;

  frame_tick u_frame_tick (
    .frame_clk  (frame_clk),
    .reset      (reset),
    .scan_pos   (scan_pos),
    .frame_start(frame_start)
  );

  beat_detector u_beat_detector (
    .frame_clk    (frame_clk),
    .reset        (reset),
    .sample_power (sample_power),
    .sample_strobe(sample_strobe),
    .beat_hit     (beat_hit),
    .beating      (beating)
  );

  motion_manager #(
    .step_frames(step_frames)
  ) u_motion_manager (
    .frame_clk  (frame_clk),
    .reset      (reset),
    .frame_start(frame_start),
    .beat_hit   (beat_hit),
    .beating    (beating),
    .dancer_en  (dancer_en),
    .home       (home),
    .dancer_pos (dancer_pos),
    .direction  (direction)
  );

  // LED flags
  assign status = '{
    frame_start: frame_start,
    beat_hit:    beat_hit,
    beating:     beating,
    direction:   direction
  };

endmodule

// ==== verilog/frame_tick.sv ====
////////////////////
// one pulse per frame from the video scan position
// the first pulse after reset needs a nonzero scan first
////////////////////
`timescale 1ns/1ps

module frame_tick (
  input  logic                frame_clk,
  input  logic                reset,
  input  scan_pkg::screen_pos_t scan_pos,
  output logic                frame_start
);

  // scan sits at the top-left pixel
  logic at_origin;

  // set once the scan has left the origin, cleared when we fire
  logic armed;

  assign at_origin = (scan_pos == scan_pkg::screen_pos_t'(0));

  always_ff @(posedge frame_clk) begin
    if (reset) begin
      armed       <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      // registered pulse, one cycle after the origin edge
      frame_start <= armed && at_origin;
      if (!at_origin) begin
        armed <= 1'b1;
      end else if (armed) begin
        // origin may be held for many cycles, fire only once
        armed <= 1'b0;
      end
    end
  end

endmodule
